/* sources.f */
+incdir+rtl
rtl/ex_op_pkg.sv
rtl/ex_pipe_pkg.sv
rtl/ex_alu.sv
rtl/ex_mult.sv
rtl/ex_ctrl.sv
rtl/ex_wb_port.sv
rtl/ex_stage.sv
dv/ex_stage_tb.sv

/* Bender.yml */
package:
  name: ex_stage

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ex_op_pkg.sv
      - rtl/ex_pipe_pkg.sv
      - rtl/ex_alu.sv
      - rtl/ex_mult.sv
      - rtl/ex_ctrl.sv
      - rtl/ex_wb_port.sv
      - rtl/ex_stage.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - dv/ex_stage_tb.sv

/* dv/ex_stage_tb.sv */
`include "ex_consts.svh"

module ex_stage_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import ex_op_pkg::*;
  import ex_pipe_pkg::*;

  localparam int N_ALU_OPS    = 300;
  localparam int N_DIRECTED   = 100;
  // Several times the expected run length
  localparam int MAX_CYCLES   = (N_ALU_OPS + N_DIRECTED) * 15 / 2;
  // Longest legal wait for ex_valid_o after a request
  localparam int ACCEPT_LIMIT = 20;

  logic      clk = 1'b0;
  logic      rst_n;
  alu_req_t  alu_req_i;
  mult_req_t mult_req_i;
  logic      csr_access_i;
  word_t     csr_rdata_i;
  logic      lsu_en_i;
  logic      lsu_ready_ex_i;
  logic      lsu_err_i;
  word_t     lsu_rdata_i;
  logic      branch_in_ex_i;
  logic      regfile_alu_we_i;
  reg_addr_t regfile_alu_waddr_i;
  logic      regfile_we_i;
  reg_addr_t regfile_waddr_i;
  logic      wb_ready_i;
  wport_t    fw_port_o;
  wport_t    wb_port_o;
  logic      branch_decision_o;
  word_t     jump_target_o;
  logic      ex_ready_o;
  logic      ex_valid_o;
  logic      mult_multicycle_o;

  // Reference model state
  int        stall_cnt_q;
  logic      done_q;
  logic      wb_we_q;
  reg_addr_t wb_addr_q;
  logic      accepted_q;
  int        cycle_cnt = 0;
  // Reference model outputs
  logic      mh_req;
  logic      exp_busy;
  logic      exp_units_ready;
  logic      exp_valid;
  logic      exp_ready;
  logic      exp_cmp;
  logic      fw_check_en;
  word_t     exp_fw_data;

  ex_stage dut (.*);

  always #5 clk = ~clk;

  //////////////////////////////////////////////////
  // Failure reporting
  //////////////////////////////////////////////////

  task automatic fail_run(string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(string name, logic [63:0] exp_v, logic [63:0] act_v);
    fail_run($sformatf("FAIL %s expected 0x%0h actual 0x%0h", name, exp_v, act_v));
  endtask

  //////////////////////////////////////////////////
  // Reference functions from the RV32IM rules
  //////////////////////////////////////////////////

  function automatic logic ref_cmp(alu_op_e op, word_t a, word_t b);
    case (op)
      ALU_EQ:  return a == b;
      ALU_NE:  return a != b;
      ALU_LT:  return $signed(a) < $signed(b);
      ALU_GE:  return $signed(a) >= $signed(b);
      ALU_LTU: return a < b;
      ALU_GEU: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic word_t ref_alu(alu_op_e op, word_t a, word_t b);
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLL:  return a << b[4:0];
      ALU_SRL:  return a >> b[4:0];
      ALU_SRA:  return word_t'($signed(a) >>> b[4:0]);
      ALU_SLT:  return word_t'($signed(a) < $signed(b));
      ALU_SLTU: return word_t'(a < b);
      default:  return word_t'(ref_cmp(op, a, b));
    endcase
  endfunction

  // Full 64-bit product, operands extended per the M extension
  function automatic word_t ref_mult(mult_op_e op, word_t a, word_t b);
    logic [2*`EX_XLEN-1:0] ea;
    logic [2*`EX_XLEN-1:0] eb;
    logic [2*`EX_XLEN-1:0] p;
    ea = {{`EX_XLEN{a[`EX_XLEN-1] && (op != MULT_MULHU)}}, a};
    eb = {{`EX_XLEN{b[`EX_XLEN-1] && (op == MULT_MULH)}}, b};
    p  = ea * eb;
    return (op == MULT_MUL) ? p[`EX_XLEN-1:0] : p[2*`EX_XLEN-1:`EX_XLEN];
  endfunction

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  always_comb begin
    mh_req          = mult_req_i.enable && (mult_req_i.op != MULT_MUL);
    // High multiply stalls from issue until its count runs out
    exp_busy        = (stall_cnt_q != 0) || (!done_q && mh_req);
    exp_units_ready = !exp_busy && lsu_ready_ex_i && wb_ready_i;
    exp_valid       = (alu_req_i.enable || mult_req_i.enable || csr_access_i || lsu_en_i)
                      && exp_units_ready;
    exp_ready       = exp_units_ready || branch_in_ex_i;
    exp_cmp         = ref_cmp(alu_req_i.op, alu_req_i.a, alu_req_i.b);
    fw_check_en     = 1'b1;
    if (csr_access_i) begin
      exp_fw_data = csr_rdata_i;
    end else if (alu_req_i.enable) begin
      exp_fw_data = ref_alu(alu_req_i.op, alu_req_i.a, alu_req_i.b);
    end else if (mult_req_i.enable) begin
      exp_fw_data = ref_mult(mult_req_i.op, mult_req_i.a, mult_req_i.b);
      // Nothing defined on the port while busy
      fw_check_en = !exp_busy;
    end else begin
      exp_fw_data = '0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stall_cnt_q <= 0;
      done_q      <= 1'b0;
      wb_we_q     <= 1'b0;
      wb_addr_q   <= '0;
      accepted_q  <= 1'b0;
    end else begin
      accepted_q <= ex_valid_o;
      if (exp_busy) begin
        if (stall_cnt_q == `EX_MULH_CYCLES - 2) begin
          stall_cnt_q <= 0;
          done_q      <= 1'b1;
        end else begin
          stall_cnt_q <= stall_cnt_q + 1;
        end
      end else if (done_q && exp_ready) begin
        done_q <= 1'b0;
      end
      if (exp_valid) begin
        wb_we_q <= regfile_we_i && !lsu_err_i;
        if (regfile_we_i && !lsu_err_i) begin
          wb_addr_q <= regfile_waddr_i;
        end
      end else if (wb_ready_i) begin
        wb_we_q <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  assert property (@(posedge clk) $rose(rst_n) |-> !ex_valid_o)
    else report_mismatch("ex_valid_o", 0, $sampled(ex_valid_o));
  assert property (@(posedge clk) disable iff (!rst_n) ex_valid_o == exp_valid)
    else report_mismatch("ex_valid_o", $sampled(exp_valid), $sampled(ex_valid_o));
  assert property (@(posedge clk) disable iff (!rst_n) ex_ready_o == exp_ready)
    else report_mismatch("ex_ready_o", $sampled(exp_ready), $sampled(ex_ready_o));
  assert property (@(posedge clk) disable iff (!rst_n) mult_multicycle_o == exp_busy)
    else report_mismatch("mult_multicycle_o", $sampled(exp_busy),
                         $sampled(mult_multicycle_o));
  assert property (@(posedge clk) disable iff (!rst_n) fw_port_o.we == regfile_alu_we_i)
    else report_mismatch("fw_port_o.we", $sampled(regfile_alu_we_i),
                         $sampled(fw_port_o.we));
  assert property (@(posedge clk) disable iff (!rst_n)
    fw_port_o.addr == regfile_alu_waddr_i)
    else report_mismatch("fw_port_o.addr", $sampled(regfile_alu_waddr_i),
                         $sampled(fw_port_o.addr));
  assert property (@(posedge clk) disable iff (!rst_n)
    fw_check_en |-> fw_port_o.data == exp_fw_data)
    else report_mismatch("fw_port_o.data", $sampled(exp_fw_data), $sampled(fw_port_o.data));
  // Branch compares only
  assert property (@(posedge clk) disable iff (!rst_n)
    (alu_req_i.op >= ALU_EQ) |-> branch_decision_o == exp_cmp)
    else report_mismatch("branch_decision_o", $sampled(exp_cmp),
                         $sampled(branch_decision_o));
  assert property (@(posedge clk) disable iff (!rst_n) jump_target_o == alu_req_i.c)
    else report_mismatch("jump_target_o", $sampled(alu_req_i.c), $sampled(jump_target_o));
  assert property (@(posedge clk) disable iff (!rst_n) wb_port_o.we == wb_we_q)
    else report_mismatch("wb_port_o.we", $sampled(wb_we_q), $sampled(wb_port_o.we));
  assert property (@(posedge clk) disable iff (!rst_n)
    wb_we_q |-> wb_port_o.addr == wb_addr_q)
    else report_mismatch("wb_port_o.addr", $sampled(wb_addr_q), $sampled(wb_port_o.addr));
  assert property (@(posedge clk) disable iff (!rst_n) wb_port_o.data == lsu_rdata_i)
    else report_mismatch("wb_port_o.data", $sampled(lsu_rdata_i), $sampled(wb_port_o.data));
  // EX/WB register frozen under back-pressure
  assert property (@(posedge clk) disable iff (!rst_n)
    !wb_ready_i |=> $stable(wb_port_o.we) && $stable(wb_port_o.addr))
    else fail_run("wb_port_o changed while wb_ready_i was low");

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      fail_run($sformatf("Run did not finish within %0d cycles", MAX_CYCLES));
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic drive_idle();
    alu_req_i           = '0;
    mult_req_i          = '0;
    csr_access_i        = 1'b0;
    csr_rdata_i         = '0;
    lsu_en_i            = 1'b0;
    lsu_ready_ex_i      = 1'b1;
    lsu_err_i           = 1'b0;
    lsu_rdata_i         = '0;
    branch_in_ex_i      = 1'b0;
    regfile_alu_we_i    = 1'b0;
    regfile_alu_waddr_i = '0;
    regfile_we_i        = 1'b0;
    regfile_waddr_i     = '0;
    wb_ready_i          = 1'b1;
  endtask

  task automatic drive_random_alu();
    alu_op_e op;
    word_t   a;
    op = alu_op_e'($urandom_range(15, 0));
    a  = $urandom;
    // Equal operands now and then so EQ and GE paths get hit
    alu_req_i           = '{enable: 1'b1, op: op, a: a,
                            b: ($urandom_range(3, 0) == 0) ? a : $urandom, c: $urandom};
    mult_req_i          = '0;
    csr_access_i        = ($urandom_range(7, 0) == 0);
    csr_rdata_i         = $urandom;
    lsu_en_i            = $urandom_range(1, 0);
    lsu_ready_ex_i      = ($urandom_range(7, 0) != 0);
    lsu_err_i           = ($urandom_range(7, 0) == 0);
    lsu_rdata_i         = $urandom;
    branch_in_ex_i      = (op >= ALU_EQ);
    regfile_alu_we_i    = ($urandom_range(3, 0) != 0);
    regfile_alu_waddr_i = reg_addr_t'($urandom);
    regfile_we_i        = $urandom_range(1, 0);
    regfile_waddr_i     = reg_addr_t'($urandom);
    wb_ready_i          = ($urandom_range(5, 0) != 0);
  endtask

  // Returns on the falling edge after ex_valid_o was seen high
  task automatic wait_accept();
    int n;
    n = 0;
    @(negedge clk);
    while (!accepted_q) begin
      if (n == ACCEPT_LIMIT) begin
        fail_run($sformatf("ex_valid_o stayed low for %0d cycles", ACCEPT_LIMIT));
      end
      n++;
      @(negedge clk);
    end
  endtask

  task automatic run_mult(mult_op_e op, word_t a, word_t b, logic hold_wb);
    @(negedge clk);
    drive_idle();
    mult_req_i          = '{enable: 1'b1, op: op, a: a, b: b};
    regfile_alu_we_i    = 1'b1;
    regfile_alu_waddr_i = reg_addr_t'($urandom);
    wb_ready_i          = !hold_wb;
    // Result parks in DONE until WB frees up
    if (hold_wb) begin
      repeat (5) @(negedge clk);
      wb_ready_i = 1'b1;
    end
    wait_accept();
    drive_idle();
  endtask

  initial begin
    void'($urandom(32'h9f18));
    rst_n = 1'b0;
    drive_idle();
    repeat (16) @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < N_ALU_OPS; i++) begin
      @(negedge clk);
      drive_random_alu();
    end

    // Multiplier corners, random pair, then a stalled result
    for (int op = 0; op < 4; op++) begin
      run_mult(mult_op_e'(op), 32'h7fff_ffff, 32'h8000_0000, 1'b0);
      run_mult(mult_op_e'(op), 32'hffff_ffff, 32'hffff_ffff, 1'b0);
      run_mult(mult_op_e'(op), 32'h8000_0000, 32'h8000_0000, 1'b0);
      run_mult(mult_op_e'(op), $urandom, $urandom, 1'b0);
      run_mult(mult_op_e'(op), $urandom, $urandom, 1'b1);
    end

    // Write-port priority: CSR, then ALU over MUL, then none
    @(negedge clk);
    alu_req_i        = '{enable: 1'b1, op: ALU_ADD, a: $urandom, b: $urandom, c: $urandom};
    mult_req_i       = '{enable: 1'b1, op: MULT_MUL, a: $urandom, b: $urandom};
    csr_access_i     = 1'b1;
    csr_rdata_i      = $urandom;
    regfile_alu_we_i = 1'b1;
    @(negedge clk);
    csr_access_i = 1'b0;
    @(negedge clk);
    alu_req_i.enable  = 1'b0;
    mult_req_i.enable = 1'b0;

    // EX/WB capture, clean then faulting
    for (int e = 0; e < 2; e++) begin
      @(negedge clk);
      drive_idle();
      alu_req_i       = '{enable: 1'b1, op: ALU_OR, a: $urandom, b: $urandom, c: '0};
      regfile_we_i    = 1'b1;
      regfile_waddr_i = reg_addr_t'($urandom);
      lsu_err_i       = e[0];
      @(negedge clk);
      drive_idle();
      lsu_rdata_i = $urandom;
    end

    // Back-pressure with and without a branch in EX
    @(negedge clk);
    alu_req_i       = '{enable: 1'b1, op: ALU_XOR, a: $urandom, b: $urandom, c: $urandom};
    regfile_we_i    = 1'b1;
    regfile_waddr_i = reg_addr_t'($urandom);
    for (int k = 0; k < 4; k++) begin
      @(negedge clk);
      wb_ready_i      = 1'b0;
      branch_in_ex_i  = k[0];
      regfile_waddr_i = reg_addr_t'($urandom);
    end
    @(negedge clk);
    drive_idle();
    repeat (4) @(negedge clk);

    $display("Test passed");
    $finish;
  end

endmodule

/* rtl/ex_stage.sv */
module ex_stage (
  input  logic                   clk,
  input  logic                   rst_n,
  // Requests from ID
  input  ex_pipe_pkg::alu_req_t  alu_req_i,
  input  ex_pipe_pkg::mult_req_t mult_req_i,
  input  logic                   csr_access_i,
  input  ex_pipe_pkg::word_t     csr_rdata_i,
  // LSU
  input  logic                   lsu_en_i,
  input  logic                   lsu_ready_ex_i,
  input  logic                   lsu_err_i,
  input  ex_pipe_pkg::word_t     lsu_rdata_i,
  // Destination info from ID
  input  logic                   branch_in_ex_i,
  input  logic                   regfile_alu_we_i,
  input  ex_pipe_pkg::reg_addr_t regfile_alu_waddr_i,
  input  logic                   regfile_we_i,
  input  ex_pipe_pkg::reg_addr_t regfile_waddr_i,
  input  logic                   wb_ready_i,
  // Write ports
  output ex_pipe_pkg::wport_t    fw_port_o,
  output ex_pipe_pkg::wport_t    wb_port_o,
  // To IF
  output logic                   branch_decision_o,
  output ex_pipe_pkg::word_t     jump_target_o,
  // Handshake
  output logic                   ex_ready_o,
  output logic                   ex_valid_o,
  output logic                   mult_multicycle_o
);

  import ex_op_pkg::*;
  import ex_pipe_pkg::*;

  word_t   alu_result;
  logic    alu_cmp;
  word_t   mult_result;
  logic    mult_ready;
  wp_src_e wp_sel;
  logic    wb_load;
  logic    wb_flush;

  // Branch target is operand c as is
  assign branch_decision_o = alu_cmp;
  assign jump_target_o     = alu_req_i.c;

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////

  ex_ctrl u_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .alu_en_i       (alu_req_i.enable),
    .mult_en_i      (mult_req_i.enable),
    .csr_access_i   (csr_access_i),
    .lsu_en_i       (lsu_en_i),
    .mult_ready_i   (mult_ready),
    .lsu_ready_ex_i (lsu_ready_ex_i),
    .wb_ready_i     (wb_ready_i),
    .branch_in_ex_i (branch_in_ex_i),
    .wp_sel_o       (wp_sel),
    .wb_load_o      (wb_load),
    .wb_flush_o     (wb_flush),
    .ex_ready_o     (ex_ready_o),
    .ex_valid_o     (ex_valid_o)
  );

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  ex_alu u_alu (
    .req_i    (alu_req_i),
    .result_o (alu_result),
    .cmp_o    (alu_cmp)
  );

  // ex_ready_o releases a held high product
  ex_mult u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (mult_req_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  ex_wb_port u_wb_port (
    .clk                 (clk),
    .rst_n               (rst_n),
    .wp_sel_i            (wp_sel),
    .alu_result_i        (alu_result),
    .mult_result_i       (mult_result),
    .csr_rdata_i         (csr_rdata_i),
    .regfile_alu_we_i    (regfile_alu_we_i),
    .regfile_alu_waddr_i (regfile_alu_waddr_i),
    .wb_load_i           (wb_load),
    .wb_flush_i          (wb_flush),
    .regfile_we_i        (regfile_we_i),
    .lsu_err_i           (lsu_err_i),
    .regfile_waddr_i     (regfile_waddr_i),
    .lsu_rdata_i         (lsu_rdata_i),
    .fw_port_o           (fw_port_o),
    .wb_port_o           (wb_port_o)
  );

endmodule

/* rtl/ex_wb_port.sv */
module ex_wb_port (
  input  logic                   clk,
  input  logic                   rst_n,
  input  ex_op_pkg::wp_src_e     wp_sel_i,
  input  ex_pipe_pkg::word_t     alu_result_i,
  input  ex_pipe_pkg::word_t     mult_result_i,
  input  ex_pipe_pkg::word_t     csr_rdata_i,
  input  logic                   regfile_alu_we_i,
  input  ex_pipe_pkg::reg_addr_t regfile_alu_waddr_i,
  input  logic                   wb_load_i,
  input  logic                   wb_flush_i,
  input  logic                   regfile_we_i,
  input  logic                   lsu_err_i,
  input  ex_pipe_pkg::reg_addr_t regfile_waddr_i,
  input  ex_pipe_pkg::word_t     lsu_rdata_i,
  output ex_pipe_pkg::wport_t    fw_port_o,
  output ex_pipe_pkg::wport_t    wb_port_o
);

  import ex_op_pkg::*;
  import ex_pipe_pkg::*;

  logic      wb_we_q;
  reg_addr_t wb_waddr_q;
  logic      wb_we_d;

  //////////////////////////////////////////////////
  // ALU write port
  //////////////////////////////////////////////////

  assign fw_port_o.we   = regfile_alu_we_i;
  assign fw_port_o.addr = regfile_alu_waddr_i;

  always_comb begin
    case (wp_sel_i)
      WP_CSR:  fw_port_o.data = csr_rdata_i;
      WP_ALU:  fw_port_o.data = alu_result_i;
      WP_MULT: fw_port_o.data = mult_result_i;
      default: fw_port_o.data = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // EX/WB register
  //////////////////////////////////////////////////

  // Faulting loads never reach the register file
  assign wb_we_d = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_we_q    <= 1'b0;
      wb_waddr_q <= '0;
    end else if (wb_load_i) begin
      wb_we_q <= wb_we_d;
      // address only follows a write that will happen
      if (wb_we_d) begin
        wb_waddr_q <= regfile_waddr_i;
      end
    end else if (wb_flush_i) begin
      wb_we_q <= 1'b0;
    end
  end

  // Load data arrives from the LSU in the WB cycle itself
  assign wb_port_o.we   = wb_we_q;
  assign wb_port_o.addr = wb_waddr_q;
  assign wb_port_o.data = lsu_rdata_i;

  // Control never asks for both at once
  assert property (@(posedge clk) disable iff (!rst_n)
    !(wb_load_i && wb_flush_i));

endmodule

/* rtl/ex_ctrl.sv */
module ex_ctrl (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                alu_en_i,
  input  logic                mult_en_i,
  input  logic                csr_access_i,
  input  logic                lsu_en_i,
  input  logic                mult_ready_i,
  input  logic                lsu_ready_ex_i,
  input  logic                wb_ready_i,
  input  logic                branch_in_ex_i,
  output ex_op_pkg::wp_src_e  wp_sel_o,
  output logic                wb_load_o,
  output logic                wb_flush_o,
  output logic                ex_ready_o,
  output logic                ex_valid_o
);

  import ex_op_pkg::*;

  logic units_ready;
  logic any_en;

  //////////////////////////////////////////////////
  // Stall control
  //////////////////////////////////////////////////

  // All units that can hold the stage
  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;
  assign any_en      = alu_en_i | mult_en_i | csr_access_i | lsu_en_i;

  // Valid travels right and does not look at ex_ready_o
  assign ex_valid_o = any_en & units_ready;
  // Branches resolve in EX and never wait on WB
  assign ex_ready_o = units_ready | branch_in_ex_i;

  //////////////////////////////////////////////////
  // Write port source and EX/WB commands
  //////////////////////////////////////////////////

  // CSR wins over ALU, ALU over the multiplier
  always_comb begin
    if (csr_access_i) begin
      wp_sel_o = WP_CSR;
    end else if (alu_en_i) begin
      wp_sel_o = WP_ALU;
    end else if (mult_en_i) begin
      wp_sel_o = WP_MULT;
    end else begin
      wp_sel_o = WP_NONE;
    end
  end

  // Capture on a leaving instruction
  assign wb_load_o  = ex_valid_o;
  // WB drains with nothing behind it
  assign wb_flush_o = ~ex_valid_o & wb_ready_i;

  // A stalled multiplier always belongs to an enabled request
  assert property (@(posedge clk) disable iff (!rst_n)
    !mult_ready_i |-> mult_en_i);

endmodule

/* rtl/ex_mult.sv */
`include "ex_consts.svh"

module ex_mult (
  input  logic                   clk,
  input  logic                   rst_n,
  input  ex_pipe_pkg::mult_req_t req_i,
  input  logic                   ex_ready_i,
  output ex_pipe_pkg::word_t     result_o,
  output logic                   ready_o,
  output logic                   multicycle_o
);

  import ex_op_pkg::*;
  import ex_pipe_pkg::*;

  // Counts the cycles already spent with ready_o low
  typedef logic [$clog2(`EX_MULH_CYCLES)-1:0] cnt_t;

  logic                          sext_a;
  logic                          sext_b;
  logic signed [`EX_XLEN:0]      op_a;
  logic signed [`EX_XLEN:0]      op_b;
  logic signed [2*`EX_XLEN+1:0]  prod;
  logic                          mulh_req;
  mult_state_e                   state_q;
  mult_state_e                   state_d;
  cnt_t                          cnt_q;
  cnt_t                          cnt_d;
  logic                          hi_load;
  word_t                         hi_q;

  //////////////////////////////////////////////////
  // 33x33 signed multiplier
  //////////////////////////////////////////////////

  // MULH signs both operands, MULHSU only a, MULHU neither
  assign sext_a = (req_i.op == MULT_MULH) || (req_i.op == MULT_MULHSU);
  assign sext_b = (req_i.op == MULT_MULH);

  assign op_a = {sext_a & req_i.a[`EX_XLEN-1], req_i.a};
  assign op_b = {sext_b & req_i.b[`EX_XLEN-1], req_i.b};
  assign prod = op_a * op_b;

  // Anything but MUL takes the multi-cycle path
  assign mulh_req = req_i.enable && (req_i.op != MULT_MUL);

  //////////////////////////////////////////////////
  // High-product sequencer
  //////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    cnt_d        = cnt_q;
    hi_load      = 1'b0;
    ready_o      = 1'b1;
    multicycle_o = 1'b0;
    case (state_q)
      MS_IDLE: begin
        // Issue cycle already counts as the first stalled one
        if (mulh_req) begin
          ready_o      = 1'b0;
          multicycle_o = 1'b1;
          cnt_d        = cnt_t'(1);
          state_d      = MS_BUSY;
        end
      end
      MS_BUSY: begin
        ready_o      = 1'b0;
        multicycle_o = 1'b1;
        if (cnt_q == cnt_t'(`EX_MULH_CYCLES - 2)) begin
          hi_load = 1'b1;
          state_d = MS_DONE;
        end else begin
          cnt_d = cnt_q + cnt_t'(1);
        end
      end
      MS_DONE: begin
        // Result stays on the port until the pipeline moves on
        if (ex_ready_i) begin
          state_d = MS_IDLE;
        end
      end
      default: state_d = MS_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MS_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // Upper half captured on the last busy cycle
  always_ff @(posedge clk) begin
    if (hi_load) begin
      hi_q <= prod[2*`EX_XLEN-1:`EX_XLEN];
    end
  end

  // Low product is combinational for MUL
  assign result_o = (state_q == MS_DONE) ? hi_q : prod[`EX_XLEN-1:0];

  // ID must not change the operands under a running high multiply
  assert property (@(posedge clk) disable iff (!rst_n)
    !ready_o |=> $stable(req_i));

endmodule

/* rtl/ex_alu.sv */
`include "ex_consts.svh"

module ex_alu (
  input  ex_pipe_pkg::alu_req_t req_i,
  output ex_pipe_pkg::word_t    result_o,
  output logic                  cmp_o
);

  import ex_op_pkg::*;
  import ex_pipe_pkg::*;

  // Adder
  logic              sub;
  word_t             b_add;
  word_t             sum;
  // Comparator flags
  logic              eq;
  logic              lt_s;
  logic              lt_u;
  // Shifter
  logic              shift_left;
  word_t             shift_in;
  logic [`EX_XLEN:0] shift_ext;
  logic [`EX_XLEN:0] shift_res;
  word_t             shift_out;

  //////////////////////////////////////////////////
  // Adder and comparators
  //////////////////////////////////////////////////

  // SUB as a + ~b + 1
  assign sub   = (req_i.op == ALU_SUB);
  assign b_add = sub ? ~req_i.b : req_i.b;
  assign sum   = req_i.a + b_add + word_t'(sub);

  assign eq   = (req_i.a == req_i.b);
  assign lt_s = ($signed(req_i.a) < $signed(req_i.b));
  assign lt_u = (req_i.a < req_i.b);

  //////////////////////////////////////////////////
  // Barrel shifter
  //////////////////////////////////////////////////

  // One right shifter; left shifts run on the bit-reversed operand
  assign shift_left = (req_i.op == ALU_SLL);

  always_comb begin
    for (int i = 0; i < `EX_XLEN; i++) begin
      shift_in[i] = shift_left ? req_i.a[`EX_XLEN-1-i] : req_i.a[i];
    end
  end

  // Extra top bit carries the sign only for SRA
  assign shift_ext = {(req_i.op == ALU_SRA) & req_i.a[`EX_XLEN-1], shift_in};
  // Shift amount is the low 5 bits of b
  assign shift_res = $signed(shift_ext) >>> req_i.b[4:0];

  always_comb begin
    for (int i = 0; i < `EX_XLEN; i++) begin
      shift_out[i] = shift_left ? shift_res[`EX_XLEN-1-i] : shift_res[i];
    end
  end

  //////////////////////////////////////////////////
  // Branch decision and result select
  //////////////////////////////////////////////////

  // Only meaningful for EQ through GEU
  always_comb begin
    case (req_i.op)
      ALU_EQ:  cmp_o = eq;
      ALU_NE:  cmp_o = ~eq;
      ALU_LT:  cmp_o = lt_s;
      ALU_GE:  cmp_o = ~lt_s;
      ALU_LTU: cmp_o = lt_u;
      ALU_GEU: cmp_o = ~lt_u;
      default: cmp_o = 1'b0;
    endcase
  end

  always_comb begin
    case (req_i.op)
      ALU_ADD,
      ALU_SUB:  result_o = sum;
      ALU_AND:  result_o = req_i.a & req_i.b;
      ALU_OR:   result_o = req_i.a | req_i.b;
      ALU_XOR:  result_o = req_i.a ^ req_i.b;
      ALU_SLL,
      ALU_SRL,
      ALU_SRA:  result_o = shift_out;
      ALU_SLT:  result_o = word_t'(lt_s);
      ALU_SLTU: result_o = word_t'(lt_u);
      // Branch compares return the decision bit
      default:  result_o = word_t'(cmp_o);
    endcase
  end

endmodule

/* rtl/ex_pipe_pkg.sv */
`include "ex_consts.svh"

package ex_pipe_pkg;

  //////////////////////////////////////////////////
  // Basic vectors
  //////////////////////////////////////////////////

  // One integer data word
  typedef logic [`EX_XLEN-1:0] word_t;

  // Register file write address
  typedef logic [`EX_RADDR_W-1:0] reg_addr_t;

  //////////////////////////////////////////////////
  // Requests from ID
  //////////////////////////////////////////////////

  // ALU request
  // c carries the jump target for branches
  typedef struct packed {
    logic               enable;
    ex_op_pkg::alu_op_e op;
    word_t              a;
    word_t              b;
    word_t              c;
  } alu_req_t;

  // Multiplier request
  // Held stable by ID while the high product is computed
  typedef struct packed {
    logic                enable;
    ex_op_pkg::mult_op_e op;
    word_t               a;
    word_t               b;
  } mult_req_t;

  //////////////////////////////////////////////////
  // Register file write ports
  //////////////////////////////////////////////////

  // Shared by the forward port and the load/store write port
  typedef struct packed {
    logic      we;
    reg_addr_t addr;
    word_t     data;
  } wport_t;

endpackage

/* rtl/ex_op_pkg.sv */
`include "ex_consts.svh"

package ex_op_pkg;

  //////////////////////////////////////////////////
  // ALU operators
  //////////////////////////////////////////////////

  // Arithmetic, logic and shifts first
  // Branch compares kept contiguous at the top of the range
  typedef enum logic [`EX_ALU_OP_W-1:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13,
    ALU_LTU  = 4'd14,
    ALU_GEU  = 4'd15
  } alu_op_e;

  // Multiplier operators, MUL is the only single-cycle one
  typedef enum logic [`EX_MULT_OP_W-1:0] {
    MULT_MUL    = 2'd0,
    MULT_MULH   = 2'd1,
    MULT_MULHSU = 2'd2,
    MULT_MULHU  = 2'd3
  } mult_op_e;

  // High-product sequencer
  typedef enum logic [1:0] {
    MS_IDLE = 2'd0,
    MS_BUSY = 2'd1,
    MS_DONE = 2'd2
  } mult_state_e;

  // Source of the ALU write port data
  typedef enum logic [1:0] {
    WP_NONE = 2'd0,
    WP_ALU  = 2'd1,
    WP_MULT = 2'd2,
    WP_CSR  = 2'd3
  } wp_src_e;

endpackage

/* rtl/ex_consts.svh */
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

//////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////

// Integer data word
`define EX_XLEN        32
// Register file address, includes the FP/special bank bit
`define EX_RADDR_W     6

//////////////////////////////////////////////////
// Operator encodings and latencies
//////////////////////////////////////////////////

`define EX_ALU_OP_W    4
`define EX_MULT_OP_W   2
// Total cycles of MULH/MULHSU/MULHU, counted from issue to result
`define EX_MULH_CYCLES 3

`endif
